// File: fetch_params.svh
// global constants of the fetch front end
// IRAM_WAIT must stay in 0..15 because the wait timer is 4 bits wide
// IRAM_DEPTH and BTB_ENTRIES must be powers of two
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

`define RESET_PC     32'h200  // first fetch address after reset
`define BTB_ENTRIES  16       // direct-mapped, one entry per index
`define IRAM_DEPTH   256      // 32-bit words, covers pc bits 9..2
`define IRAM_WAIT    2        // extra cycles per ram read

`endif

// File: rv32i_fetch_pkg.sv
// types shared by the fetch front end and its testbench
// widths derive from the defines in fetch_params.svh
`include "fetch_params.svh"

package rv32i_fetch_pkg;

  localparam int BTB_IDX_W = $clog2(`BTB_ENTRIES);  // index bits above pc[1:0]
  localparam int IRAM_AW   = $clog2(`IRAM_DEPTH);   // word address bits

  typedef logic [31:0] word_t;                     // pc, instruction, address

  typedef logic [BTB_IDX_W-1:0] btb_idx_t;         // pc[BTB_IDX_W+1:2]

  typedef logic [29-BTB_IDX_W:0] btb_tag_t;        // pc bits above the index

  typedef logic [IRAM_AW-1:0] iram_addr_t;         // ram word address

  typedef logic [3:0] wait_cnt_t;                  // wait-state count

  typedef enum logic [1:0] {
    REQ,   // start a ram read
    WAIT,  // ram access in progress
    HOLD   // instruction offered to execute
  } fetch_state_t;

endpackage

// File: fetch_execute_if.sv
`timescale 1ns/1ps
// fetch to execute handoff with a valid/ready pair
// payload is stable while valid is high and ready is low
interface fetch_execute_if
  import rv32i_fetch_pkg::*;
();

  word_t pc;          // pc of the fetched instruction
  word_t pc4;         // pc plus 4, link value for execute
  word_t instr;       // byte-swapped instruction word
  logic  prediction;  // btb predicted taken for this pc
  logic  valid;       // payload present
  logic  ready;       // execute accepts this cycle

  modport fetch (
    output pc,
    output pc4,
    output instr,
    output prediction,
    output valid,
    input  ready
  );

  modport execute (
    input  pc,
    input  pc4,
    input  instr,
    input  prediction,
    input  valid,
    output ready
  );

endinterface

// File: iram_if.sv
`timescale 1ns/1ps
// single-request instruction ram port, no pipelining
// rdata is valid in the first cycle where busy drops after ren
interface iram_if
  import rv32i_fetch_pkg::*;
();

  logic  ren;    // read request, one cycle
  word_t addr;   // byte address, word aligned
  word_t rdata;  // read word, little-endian in memory
  logic  busy;   // access still in progress

  modport cpu (
    output ren,
    output addr,
    input  rdata,
    input  busy
  );

  modport mem (
    input  ren,
    input  addr,
    output rdata,
    output busy
  );

endinterface

// File: fetch_ctrl.sv
`timescale 1ns/1ps
// fetch sequencing FSM, one read in flight at a time
// a redirect wins over every other event in any state
module fetch_ctrl
  import rv32i_fetch_pkg::*;
(
  input  logic         CLK,
  input  logic         nRST,
  input  logic         redirect_valid,
  input  logic         out_ready,
  input  logic         timer_done,
  input  logic         out_valid,
  output logic         pc_en,
  output logic         ren_start,
  output logic         out_load,
  output fetch_state_t state
);

  fetch_state_t next_state;
  logic         xfer;

  assign xfer      = out_valid & out_ready;                       // execute takes the item
  assign ren_start = (state == REQ) & ~redirect_valid;            // no read of a stale pc
  assign out_load  = (state == WAIT) & timer_done & ~redirect_valid; // last wait cycle
  assign pc_en     = redirect_valid | ((state == HOLD) & xfer);   // restart or advance

  always_comb begin
    next_state = state;
    case (state)
      REQ:     next_state = WAIT;                  // read issued this cycle
      WAIT:    if (timer_done) next_state = HOLD;  // word captured on this edge
      HOLD:    if (xfer) next_state = REQ;         // back-pressure keeps us here
      default: next_state = REQ;
    endcase
    if (redirect_valid) next_state = REQ;          // squash whatever was in flight
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= REQ;
    end else begin
      state <= next_state;
    end
  end

  // the pc may only move mid-access when execute redirects
  a_no_pc_en_in_wait: assert property (@(posedge CLK) disable iff (!nRST)
    (state == WAIT && pc_en) |-> redirect_valid);

  a_ren_only_in_req: assert property (@(posedge CLK) disable iff (!nRST)
    ren_start |-> (state == REQ));

endmodule

// File: iram_wait_timer.sv
`timescale 1ns/1ps
// wait-state counter for the instruction ram, reload on every read
// done is combinational with load so a pending read never looks finished
`include "fetch_params.svh"

module iram_wait_timer
  import rv32i_fetch_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  logic      load,
  output wait_cnt_t count_out,
  output logic      done
);

  localparam wait_cnt_t WAIT_LOAD = wait_cnt_t'(`IRAM_WAIT);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      count_out <= '0;                        // idle, nothing outstanding
    end else if (load) begin
      count_out <= WAIT_LOAD;                 // new access starts
    end else if (count_out != '0) begin
      count_out <= count_out - wait_cnt_t'(1); // one wait cycle gone
    end
  end

  // zero wait states give done in the first cycle after load
  assign done = (count_out == '0) & ~load;

endmodule

// File: iram.sv
`timescale 1ns/1ps
// word-addressed instruction ram, write port only for program loading
// read address latched on ren, only pc bits 9..2 are decoded
`include "fetch_params.svh"

module iram
  import rv32i_fetch_pkg::*;
(
  input  logic       CLK,
  input  logic       nRST,
  iram_if.mem        mem,
  input  logic       prog_wen,
  input  iram_addr_t prog_addr,
  input  word_t      prog_wdata,
  input  logic       done,
  output logic       busy
);

  word_t      ram [`IRAM_DEPTH];
  iram_addr_t rd_addr;   // word address of the open read
  logic       rd_open;   // a read was accepted and not yet finished

  always_ff @(posedge CLK) begin
    if (prog_wen) ram[prog_addr] <= prog_wdata;  // program load
  end

  always_ff @(posedge CLK) begin
    if (mem.ren) rd_addr <= iram_addr_t'(mem.addr >> 2);  // drop byte offset
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      rd_open <= 1'b0;
    end else if (mem.ren) begin
      rd_open <= 1'b1;
    end else if (done) begin
      rd_open <= 1'b0;   // access completed
    end
  end

  assign busy      = rd_open & ~done;  // wait states still running
  assign mem.rdata = ram[rd_addr];

  // program loading and fetching must not overlap
  a_no_load_during_fetch: assert property (@(posedge CLK) disable iff (!nRST)
    !(prog_wen && mem.ren));

endmodule

// File: btb_predictor.sv
`timescale 1ns/1ps
// direct-mapped branch target buffer, one taken bit per entry
// lookup is combinational, an update is visible from the next cycle
`include "fetch_params.svh"

module btb_predictor
  import rv32i_fetch_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  input  word_t current_pc,
  output logic  predict_taken,
  output word_t target_addr,
  input  logic  resolve_valid,
  input  word_t resolve_pc,
  input  logic  resolve_taken,
  input  word_t resolve_target
);

  logic [`BTB_ENTRIES-1:0] entry_valid;
  logic [`BTB_ENTRIES-1:0] entry_taken;
  btb_tag_t                entry_tag    [`BTB_ENTRIES];
  word_t                   entry_target [`BTB_ENTRIES];

  btb_idx_t lk_idx;
  btb_tag_t lk_tag;
  btb_idx_t up_idx;
  btb_tag_t up_tag;

  assign lk_idx = btb_idx_t'(current_pc >> 2);               // skip byte offset
  assign lk_tag = btb_tag_t'(current_pc >> (BTB_IDX_W + 2));
  assign up_idx = btb_idx_t'(resolve_pc >> 2);
  assign up_tag = btb_tag_t'(resolve_pc >> (BTB_IDX_W + 2));

  // hit needs valid, matching tag and the taken bit
  assign predict_taken = entry_valid[lk_idx] & entry_taken[lk_idx] &
                         (entry_tag[lk_idx] == lk_tag);
  assign target_addr   = entry_target[lk_idx];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      entry_valid <= '0;                    // empty table after reset
    end else if (resolve_valid) begin
      entry_valid[up_idx] <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (resolve_valid) begin
      entry_tag[up_idx]    <= up_tag;         // overwrite, no replacement policy
      entry_target[up_idx] <= resolve_target;
      entry_taken[up_idx]  <= resolve_taken;  // not taken clears the prediction
    end
  end

endmodule

// File: fetch_stage.sv
`timescale 1ns/1ps
// pc register, next-pc select, endian swap and fetch output registers
// prediction and target are captured with the item so a later btb update cannot split them
`include "fetch_params.svh"

module fetch_stage
  import rv32i_fetch_pkg::*;
(
  input  logic           CLK,
  input  logic           nRST,
  fetch_execute_if.fetch fetch_exif,
  iram_if.cpu            iram,
  input  logic           pc_en,
  input  logic           ren_start,
  input  logic           out_load,
  input  logic           redirect_valid,
  input  word_t          redirect_addr,
  input  logic           predict_taken,
  input  word_t          target_addr,
  output word_t          current_pc
);

  word_t pc;
  word_t pc4;
  word_t npc;
  word_t instr;
  word_t pred_target;  // btb target of the held item
  logic  xfer;

  assign pc4        = pc + 32'd4;
  assign current_pc = pc;                                  // btb lookup key
  assign xfer       = fetch_exif.valid & fetch_exif.ready;
  assign npc        = redirect_valid        ? redirect_addr :
                      fetch_exif.prediction ? pred_target : pc4;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= `RESET_PC;
    end else if (pc_en) begin
      pc <= npc;
    end
  end

  assign iram.addr = pc;
  assign iram.ren  = ren_start;
  assign instr     = {iram.rdata[7:0], iram.rdata[15:8],     // memory is little-endian
                      iram.rdata[23:16], iram.rdata[31:24]};

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      fetch_exif.valid <= 1'b0;
    end else if (redirect_valid) begin
      fetch_exif.valid <= 1'b0;   // squash the held item
    end else if (out_load) begin
      fetch_exif.valid <= 1'b1;
    end else if (xfer) begin
      fetch_exif.valid <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (out_load) begin
      fetch_exif.pc         <= pc;
      fetch_exif.pc4        <= pc4;
      fetch_exif.instr      <= instr;
      fetch_exif.prediction <= predict_taken;
      pred_target           <= target_addr;
    end
  end

  // one access at a time, an offered item never overlaps an open ram read
  a_valid_after_access: assert property (@(posedge CLK) disable iff (!nRST)
    fetch_exif.valid |-> !iram.busy);

endmodule

// File: fetch_top.sv
`timescale 1ns/1ps
// fetch front end top, the execute side is outside this block
// the program must be loaded while no fetch is running
module fetch_top
  import rv32i_fetch_pkg::*;
(
  input  logic       CLK,
  input  logic       nRST,
  input  logic       prog_wen,
  input  iram_addr_t prog_addr,
  input  word_t      prog_wdata,
  input  logic       redirect_valid,
  input  word_t      redirect_addr,
  input  logic       resolve_valid,
  input  word_t      resolve_pc,
  input  logic       resolve_taken,
  input  word_t      resolve_target,
  output logic       out_valid,
  input  logic       out_ready,
  output word_t      out_pc,
  output word_t      out_pc4,
  output word_t      out_instr,
  output logic       out_pred
);

  fetch_execute_if exif ();
  iram_if          iram_bus ();

  logic         pc_en;
  logic         ren_start;
  logic         out_load;
  logic         timer_done;
  logic         predict_taken;
  word_t        current_pc;
  word_t        target_addr;
  wait_cnt_t    timer_count;
  fetch_state_t ctrl_state;

  // execute side of the handoff goes to plain ports
  assign out_valid  = exif.valid;
  assign out_pc     = exif.pc;
  assign out_pc4    = exif.pc4;
  assign out_instr  = exif.instr;
  assign out_pred   = exif.prediction;
  assign exif.ready = out_ready;

  fetch_ctrl u_ctrl (
    .CLK(CLK), .nRST(nRST), .redirect_valid(redirect_valid), .out_ready(out_ready),
    .timer_done(timer_done), .out_valid(exif.valid), .pc_en(pc_en),
    .ren_start(ren_start), .out_load(out_load), .state(ctrl_state)
  );

  iram_wait_timer u_timer (
    .CLK(CLK), .nRST(nRST), .load(ren_start), .count_out(timer_count), .done(timer_done)
  );

  iram u_iram (
    .CLK(CLK), .nRST(nRST), .mem(iram_bus.mem), .prog_wen(prog_wen),
    .prog_addr(prog_addr), .prog_wdata(prog_wdata), .done(timer_done),
    .busy(iram_bus.busy)
  );

  btb_predictor u_btb (
    .CLK(CLK), .nRST(nRST), .current_pc(current_pc), .predict_taken(predict_taken),
    .target_addr(target_addr), .resolve_valid(resolve_valid), .resolve_pc(resolve_pc),
    .resolve_taken(resolve_taken), .resolve_target(resolve_target)
  );

  fetch_stage u_stage (
    .CLK(CLK), .nRST(nRST), .fetch_exif(exif.fetch), .iram(iram_bus.cpu),
    .pc_en(pc_en), .ren_start(ren_start), .out_load(out_load),
    .redirect_valid(redirect_valid), .redirect_addr(redirect_addr),
    .predict_taken(predict_taken), .target_addr(target_addr), .current_pc(current_pc)
  );

  // holding an item means the stage shows it and the access has fully drained
  a_hold_consistent: assert property (@(posedge CLK) disable iff (!nRST)
    (ctrl_state == HOLD) |-> (exif.valid && timer_count == '0));

endmodule

// File: tb_fetch_top.sv
`timescale 1ns/1ps
// self-checking testbench, plays the execute stage and the branch resolver
// the program is written while nRST is low, reset then stays low 16 more cycles
`include "fetch_params.svh"

module tb_fetch_top
  import rv32i_fetch_pkg::*;
();

  localparam int MAX_XFERS = 32;  // largest transfer count of one test
  localparam int LIMIT = `IRAM_DEPTH + 32 + 5 * MAX_XFERS * (`IRAM_WAIT + 4) * 2;

  logic CLK, nRST, prog_wen, redirect_valid, resolve_valid, resolve_taken;
  logic out_valid, out_ready, out_pred;
  iram_addr_t prog_addr;
  word_t prog_wdata, redirect_addr, resolve_pc, resolve_target, out_pc, out_pc4, out_instr;

  word_t      prog_mem [`IRAM_DEPTH];  // copy of the loaded program
  logic       m_valid  [`BTB_ENTRIES]; // model btb
  logic       m_taken  [`BTB_ENTRIES];
  btb_tag_t   m_tag    [`BTB_ENTRIES];
  word_t      m_target [`BTB_ENTRIES];
  logic [31:0] rng = 32'h563a;
  word_t exp_pc, h_pc, h_instr;
  logic  held, h_pred;
  int    n_xfer, n_pred, n_checks, errors, cycle_cnt;

  fetch_top uut (.*);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // memory holds little-endian words, the instruction is the byte swap
  function automatic word_t exp_instr(input word_t pc);
    word_t w;
    w = prog_mem[pc[IRAM_AW+1:2]];
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  function automatic logic model_pred(input word_t pc);
    btb_idx_t i;
    i = pc[BTB_IDX_W+1:2];
    return m_valid[i] && m_taken[i] && (m_tag[i] == btb_tag_t'(pc >> (BTB_IDX_W + 2)));
  endfunction

  // compare process, sampled mid-cycle where every output is settled
  always @(negedge CLK) begin
    if (nRST) begin
      if (held && (!out_valid || out_pc !== h_pc ||
                   out_instr !== h_instr || out_pred !== h_pred)) begin
        $display("[ERROR] held item changed: out_pc %h out_instr %h, was %h %h",
                 out_pc, out_instr, h_pc, h_instr);
        errors++;
      end
      held    = out_valid && !out_ready && !redirect_valid;  // must survive next edge
      h_pc    = out_pc;
      h_instr = out_instr;
      h_pred  = out_pred;
      if (redirect_valid) begin
        exp_pc = redirect_addr;  // wins over a transfer in this cycle
      end else if (out_valid && out_ready) begin
        n_checks += 4;
        if (out_pc !== exp_pc) begin
          $display("[ERROR] out_pc got %h expected %h", out_pc, exp_pc);
          errors++;
        end
        if (out_pc4 !== exp_pc + 32'd4) begin
          $display("[ERROR] out_pc4 got %h expected %h", out_pc4, exp_pc + 32'd4);
          errors++;
        end
        if (out_instr !== exp_instr(exp_pc)) begin
          $display("[ERROR] out_instr got %h expected %h", out_instr, exp_instr(exp_pc));
          errors++;
        end
        if (out_pred !== model_pred(exp_pc)) begin
          $display("[ERROR] out_pred got %h expected %h", out_pred, model_pred(exp_pc));
          errors++;
        end
        n_xfer++;
        if (out_pred === 1'b1) begin
          n_pred++;  // taken predictions made by the dut
        end
        if (model_pred(exp_pc)) begin
          exp_pc = m_target[exp_pc[BTB_IDX_W+1:2]];  // follow the predicted branch
        end else begin
          exp_pc = exp_pc + 32'd4;
        end
      end
      if (resolve_valid) begin  // written at the coming edge, like the dut
        m_valid[resolve_pc[BTB_IDX_W+1:2]]  = 1'b1;
        m_taken[resolve_pc[BTB_IDX_W+1:2]]  = resolve_taken;
        m_tag[resolve_pc[BTB_IDX_W+1:2]]    = btb_tag_t'(resolve_pc >> (BTB_IDX_W + 2));
        m_target[resolve_pc[BTB_IDX_W+1:2]] = resolve_target;
      end
    end
  end

  initial begin
    while (cycle_cnt < LIMIT) begin
      @(posedge CLK);
      cycle_cnt++;
    end
    $display("timeout: run stopped after %0d cycles without finishing", cycle_cnt);
    $display("CHECKS FAILED");
    $finish;
  end

  task automatic run_xfers(input int n, input bit rand_ready);
    int target;
    target = n_xfer + n;
    while (n_xfer < target) begin
      @(posedge CLK);
      rng = xorshift(rng);
      out_ready <= rand_ready ? rng[0] : 1'b1;  // random back-pressure
    end
  endtask

  task automatic redirect_to(input word_t addr);
    @(posedge CLK);
    redirect_valid <= 1'b1;
    redirect_addr  <= addr;
    @(posedge CLK);
    redirect_valid <= 1'b0;
  endtask

  task automatic resolve(input word_t pc, input logic taken, input word_t target);
    @(posedge CLK);
    resolve_valid  <= 1'b1;
    resolve_pc     <= pc;
    resolve_taken  <= taken;
    resolve_target <= target;
    @(posedge CLK);
    resolve_valid  <= 1'b0;
  endtask

  task automatic report(input string name, input int errs_before);
    $display("test %s %s  transfers=%0d", name,
             (errors == errs_before) ? "ok" : "failed", n_xfer);
  endtask

  initial begin
    int e0, lat, np0, delay;
    nRST           = 1'b0;
    prog_wen       = 1'b0;
    prog_addr      = '0;
    prog_wdata     = '0;
    redirect_valid = 1'b0;
    redirect_addr  = '0;
    out_ready      = 1'b0;
    resolve_valid  = 1'b0;
    resolve_pc     = '0;
    resolve_taken  = 1'b0;
    resolve_target = '0;
    exp_pc         = `RESET_PC;
    held           = 1'b0;
    n_xfer         = 0;
    n_pred         = 0;
    n_checks       = 0;
    errors         = 0;
    cycle_cnt      = 0;
    for (int i = 0; i < `BTB_ENTRIES; i++) m_valid[i] = 1'b0;
    for (int i = 0; i < `IRAM_DEPTH; i++) begin  // program load under reset
      @(posedge CLK);
      rng = xorshift(rng);
      prog_wen    <= 1'b1;
      prog_addr   <= iram_addr_t'(i);
      prog_wdata  <= rng;
      prog_mem[i] = rng;
    end
    @(posedge CLK);
    prog_wen  <= 1'b0;
    out_ready <= 1'b1;
    repeat (16) @(posedge CLK);

    // 1: reset state and first fetch latency
    e0 = errors;
    @(negedge CLK);
    if (out_valid !== 1'b0) begin
      $display("[ERROR] out_valid got %h expected %h during reset", out_valid, 1'b0);
      errors++;
    end
    @(posedge CLK);
    nRST <= 1'b1;
    lat = 0;
    @(negedge CLK);  // REQ cycle right after release
    while (!out_valid && lat < 64) begin
      @(negedge CLK);
      lat++;  // one rising edge since release
    end
    if (lat != `IRAM_WAIT + 2) begin
      $display("[ERROR] out_valid latency got %h expected %h", lat, `IRAM_WAIT + 2);
      errors++;
    end
    @(posedge CLK);  // first transfer is counted by now
    run_xfers(1, 1'b0);
    report("reset", e0);

    e0 = errors;  // 2: straight-line fetch
    run_xfers(MAX_XFERS, 1'b0);
    report("sequential", e0);

    e0 = errors;  // 3: random out_ready
    run_xfers(MAX_XFERS, 1'b1);
    report("backpressure", e0);

    e0 = errors;  // 4: redirects landing in REQ, WAIT or HOLD
    for (int r = 0; r < 8; r++) begin
      rng = xorshift(rng);
      delay = rng[2:0];
      repeat (delay) begin
        @(posedge CLK);
        rng = xorshift(rng);
        out_ready <= rng[0];
      end
      rng = xorshift(rng);
      redirect_to({22'h0, rng[9:2], 2'b00});
      run_xfers(3, 1'b1);
    end
    report("redirect", e0);

    // 5: taken branches at distinct btb indices, held out_ready so nothing moves
    e0 = errors;
    @(posedge CLK);
    out_ready <= 1'b0;
    resolve(32'h100, 1'b1, 32'h140);
    resolve(32'h148, 1'b1, 32'h1a0);
    resolve(32'h1ac, 1'b1, 32'h104);  // closes a loop back to 0x104
    redirect_to(32'h100);
    np0 = n_pred;
    run_xfers(16, 1'b0);
    if (n_pred - np0 < 3) begin
      $display("taken predictions missing on the loop, saw %0d", n_pred - np0);
      errors++;
    end
    @(posedge CLK);
    out_ready <= 1'b0;
    resolve(32'h100, 1'b0, 32'h140);  // not taken clears the prediction
    redirect_to(32'h100);
    np0 = n_pred;
    run_xfers(4, 1'b0);
    if (n_pred != np0) begin
      $display("cleared btb entry still predicted taken");
      errors++;
    end
    report("prediction", e0);

    $display("checks=%0d transfers=%0d errors=%0d", n_checks, n_xfer, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+.
rv32i_fetch_pkg.sv
fetch_execute_if.sv
iram_if.sv
fetch_ctrl.sv
iram_wait_timer.sv
iram.sv
btb_predictor.sv
fetch_stage.sv
fetch_top.sv
tb_fetch_top.sv

// File: Bender.yml
package:
  name: rv32i_fetch

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - rv32i_fetch_pkg.sv
      - fetch_execute_if.sv
      - iram_if.sv
      - fetch_ctrl.sv
      - iram_wait_timer.sv
      - iram.sv
      - btb_predictor.sv
      - fetch_stage.sv
      - fetch_top.sv
  - target: test
    files:
      - tb_fetch_top.sv
